/* Bender.yml */
package:
  name: dmaCtl

sources:
  - files:
      - verilog/dmaPkg.sv
      - verilog/dmaHostPort.sv
      - verilog/dmaChannelRegs.sv
      - verilog/dmaTransferEngine.sv
      - verilog/dmaCtl.sv
  - target: test
    files:
      - testbench/tbClock.sv
      - testbench/dmaCtlTb.sv

/* dmaCtl.f */
verilog/dmaPkg.sv
verilog/dmaHostPort.sv
verilog/dmaChannelRegs.sv
verilog/dmaTransferEngine.sv
verilog/dmaCtl.sv
testbench/tbClock.sv
testbench/dmaCtlTb.sv

/* testbench/dmaCtlTb.sv */
// DMA controller testbench with CPU bus tasks, register scoreboard and beat assertions
module dmaCtlTb;
  timeunit 1ns;
  timeprecision 100ps;
  import dmaPkg::*;

  localparam int NumCh = 4;

  logic             dif;
  logic             rstN;
  logic             csN;
  logic             iorN;
  logic             iowN;
  regAddrT          regAddr;
  byteT             dataIn;
  byteT             dataOut;
  logic [NumCh-1:0] dreq;
  logic             xferValid;
  logic             xferReady;
  wordT             xferAddr;
  chanT             xferChannel;
  logic             xferLast;

  // Scoreboard of the channel registers
  wordT             mBaseAddr  [NumCh];
  wordT             mBaseCount [NumCh];
  wordT             mCurAddr   [NumCh];
  wordT             mCurCount  [NumCh];
  logic [NumCh-1:0] mAuto;
  logic [NumCh-1:0] mDec;
  logic [NumCh-1:0] mMask;
  logic [NumCh-1:0] mTc;
  logic             mPtr;
  logic [NumCh-1:0] reqSeen;
  chanT             offerChan;
  wordT             expAddr;
  logic             expLast;

  tbClock i_tbClock (
    .dif (dif),
    .rstN(rstN)
  );

  dmaCtl #(
    .NumChannels(NumCh)
  ) i_dmaCtl (
    .dif        (dif),
    .rstN       (rstN),
    .csN        (csN),
    .iorN       (iorN),
    .iowN       (iowN),
    .regAddr    (regAddr),
    .dataIn     (dataIn),
    .dataOut    (dataOut),
    .dreq       (dreq),
    .xferValid  (xferValid),
    .xferReady  (xferReady),
    .xferAddr   (xferAddr),
    .xferChannel(xferChannel),
    .xferLast   (xferLast)
  );

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at the first failing check");
  endtask

  task automatic tick();
    @(posedge dif);
    #1;
  endtask

  // First requesting channel counting up from zero
  function automatic chanT lowestChannel(input logic [NumCh-1:0] cand);
    for (int i = 0; i < NumCh; i++)
    begin
      if (cand[i])
        return chanT'(i);
    end
    return '0;
  endfunction

  function automatic wordT withByte(input wordT w, input logic hi, input byteT b);
    wordT r;
    r = w;
    if (hi)
      r[15:8] = b;
    else
      r[7:0] = b;
    return r;
  endfunction

  task automatic clearModel();
    for (int i = 0; i < NumCh; i++)
    begin
      mBaseAddr[i]  = '0;
      mBaseCount[i] = '0;
      mCurAddr[i]   = '0;
      mCurCount[i]  = '0;
    end
    mAuto = '0;
    mDec  = '0;
    mMask = '1;
    mTc   = '0;
    mPtr  = 1'b0;
  endtask

  // Channel picked while idle stays with the offer, steps follow each accepted beat
  always @(posedge dif)
  begin
    if (rstN)
    begin
      if (!xferValid)
        offerChan = lowestChannel(reqSeen & ~mMask);
      reqSeen = dreq;
      if (xferValid && xferReady)
      begin
        if (mCurCount[offerChan] == 16'h0)
          mTc[offerChan] = 1'b1;
        if (mCurCount[offerChan] == 16'h0 && mAuto[offerChan])
        begin
          mCurAddr[offerChan]  = mBaseAddr[offerChan];
          mCurCount[offerChan] = mBaseCount[offerChan];
        end
        else
        begin
          if (mCurCount[offerChan] == 16'h0)
            mMask[offerChan] = 1'b1;
          mCurAddr[offerChan]  = mDec[offerChan] ? mCurAddr[offerChan] - 16'h1
                                                 : mCurAddr[offerChan] + 16'h1;
          mCurCount[offerChan] = mCurCount[offerChan] - 16'h1;
        end
      end
    end
  end

  assign expAddr = mCurAddr[offerChan];
  assign expLast = (mCurCount[offerChan] == 16'h0);

  beatChannelCheck: assert property (@(posedge dif) disable iff (!rstN)
    (xferValid && xferReady) |-> (xferChannel == offerChan))
  else failRun($sformatf("** Error: xferChannel = %h, expected %h",
    $sampled(xferChannel), $sampled(offerChan)));

  beatAddrCheck: assert property (@(posedge dif) disable iff (!rstN)
    (xferValid && xferReady) |-> (xferAddr == expAddr))
  else failRun($sformatf("** Error: xferAddr = %h, expected %h",
    $sampled(xferAddr), $sampled(expAddr)));

  beatLastCheck: assert property (@(posedge dif) disable iff (!rstN)
    (xferValid && xferReady) |-> (xferLast == expLast))
  else failRun($sformatf("** Error: xferLast = %h, expected %h",
    $sampled(xferLast), $sampled(expLast)));

  // A stalled offer keeps its payload
  stallHoldCheck: assert property (@(posedge dif) disable iff (!rstN)
    (xferValid && !xferReady) |=> (xferValid && $stable(xferAddr)
      && $stable(xferChannel) && $stable(xferLast)))
  else failRun($sformatf("** Error: stalled beat xferAddr = %h, was %h, xferValid = %h",
    $sampled(xferAddr), $past(xferAddr), $sampled(xferValid)));

  // One strobe assertion of four cycles
  task automatic busCycle(input logic isWrite, input regAddrT addr, input byteT data);
    regAddr = addr;
    dataIn  = data;
    csN     = 1'b0;
    if (isWrite)
      iowN = 1'b0;
    else
      iorN = 1'b0;
    repeat (4) tick();
    csN  = 1'b1;
    iowN = 1'b1;
    iorN = 1'b1;
    repeat (2) tick();
  endtask

  task automatic hostWrite(input regAddrT addr, input byteT data);
    int ch;
    ch = int'(addr[2:1]);
    busCycle(1'b1, addr, data);
    if (!addr[3])
    begin
      if (addr[0])
      begin
        mBaseCount[ch] = withByte(mBaseCount[ch], mPtr, data);
        mCurCount[ch]  = withByte(mCurCount[ch], mPtr, data);
      end
      else
      begin
        mBaseAddr[ch] = withByte(mBaseAddr[ch], mPtr, data);
        mCurAddr[ch]  = withByte(mCurAddr[ch], mPtr, data);
      end
      mPtr = ~mPtr;
    end
    else
    begin
      case (addr)
        RegMode:
        begin
          mAuto[data[1:0]] = data[ModeAutoInitBit];
          mDec[data[1:0]]  = data[ModeDecrementBit];
        end
        RegSingleMask:   mMask[data[1:0]] = data[MaskSetBit];
        RegAllMask:      mMask = data[NumCh-1:0];
        RegClearMask:    mMask = '0;
        RegClearBytePtr: mPtr = 1'b0;
        RegMasterClear:  clearModel();
        default:         mPtr = mPtr;
      endcase
    end
  endtask

  task automatic hostRead(input regAddrT addr);
    byteT exp;
    wordT w;
    if (!addr[3])
    begin
      w    = addr[0] ? mCurCount[addr[2:1]] : mCurAddr[addr[2:1]];
      exp  = mPtr ? w[15:8] : w[7:0];
      mPtr = ~mPtr;
    end
    else
    begin
      exp = {dreq, mTc};
      mTc = '0;
    end
    busCycle(1'b0, addr, 8'h00);
    readBackCheck: assert (dataOut == exp)
    else failRun($sformatf("** Error: dataOut = %h, expected %h", dataOut, exp));
  endtask

  task automatic programChannel(input int ch, input wordT a, input wordT c, input byteT mode);
    hostWrite(RegClearBytePtr, 8'h00);
    hostWrite(regAddrT'(2 * ch), a[7:0]);
    hostWrite(regAddrT'(2 * ch), a[15:8]);
    hostWrite(regAddrT'(2 * ch + 1), c[7:0]);
    hostWrite(regAddrT'(2 * ch + 1), c[15:8]);
    hostWrite(RegMode, mode | byteT'(ch));
    // Unmask just this channel
    hostWrite(RegSingleMask, byteT'(ch));
  endtask

  // Accepts n beats with a randomly stalling ready
  task automatic runBeats(input int n);
    int got;
    int guard;
    got   = 0;
    guard = 0;
    while (got < n)
    begin
      xferReady = ($urandom_range(0, 2) != 0);
      if (xferValid && xferReady)
        got++;
      tick();
      guard++;
      if (guard > 10 * n + 20)
        failRun("Timeout while waiting for transfer beats");
    end
    xferReady = 1'b0;
  endtask

  task automatic checkIdle(input int cycles);
    xferReady = 1'b1;
    for (int i = 0; i < cycles; i++)
    begin
      tick();
      idleCheck: assert (!xferValid)
      else failRun($sformatf("** Error: xferValid = %h, expected %h", xferValid, 1'b0));
    end
    xferReady = 1'b0;
  endtask

  // Drops requests and takes any beat still on offer
  task automatic quiesce();
    int idle;
    int guard;
    dreq      = '0;
    xferReady = 1'b1;
    idle      = 0;
    guard     = 0;
    while (idle < 4)
    begin
      tick();
      idle = xferValid ? 0 : idle + 1;
      guard++;
      if (guard > 50)
        failRun("Timeout while draining the transfer engine");
    end
    xferReady = 1'b0;
  endtask

  task automatic waitOffer();
    int guard;
    guard = 0;
    while (!xferValid)
    begin
      tick();
      guard++;
      if (guard > 30)
        failRun("Timeout while waiting for an offered beat");
    end
  endtask

  initial
  begin : mainSeq
    int   ch;
    int   lo;
    int   cLo;
    wordT a;
    wordT c;
    void'($urandom(32'h3d54));
    csN       = 1'b1;
    iorN      = 1'b1;
    iowN      = 1'b1;
    regAddr   = '0;
    dataIn    = '0;
    dreq      = '0;
    xferReady = 1'b0;
    reqSeen   = '0;
    offerChan = '0;
    clearModel();
    for (int i = 0; i < 100 && rstN !== 1'b1; i++)
      tick();
    if (rstN !== 1'b1)
      failRun("Reset was never released");

    // All channels masked out of reset
    dreq = '1;
    checkIdle(20);
    hostRead(RegStatus);
    dreq = '0;

    // Byte pointer read-back
    ch = $urandom_range(0, NumCh - 1);
    a  = wordT'($urandom);
    c  = wordT'($urandom);
    programChannel(ch, a, c, 8'h00);
    hostWrite(RegSingleMask, 8'h04 | byteT'(ch));
    hostRead(regAddrT'(2 * ch));
    hostRead(regAddrT'(2 * ch));
    hostRead(regAddrT'(2 * ch + 1));
    hostRead(regAddrT'(2 * ch + 1));
    hostRead(regAddrT'(2 * ch));
    hostWrite(RegClearBytePtr, 8'h00);
    hostRead(regAddrT'(2 * ch + 1));
    hostWrite(RegClearBytePtr, 8'h00);

    // Single run up and down, masked at terminal count
    for (int d = 0; d < 2; d++)
    begin
      ch = $urandom_range(0, NumCh - 1);
      c  = wordT'($urandom_range(2, 6));
      programChannel(ch, wordT'($urandom), c, (d == 1) ? 8'h20 : 8'h00);
      dreq[ch] = 1'b1;
      runBeats(int'(c) + 1);
      checkIdle(12);
      dreq = '0;
      hostRead(RegStatus);
      hostRead(RegStatus);
    end

    // Auto-initialize reloads from base
    ch = $urandom_range(0, NumCh - 1);
    c  = wordT'($urandom_range(2, 6));
    programChannel(ch, wordT'($urandom), c, 8'h10);
    dreq[ch] = 1'b1;
    runBeats(int'(c) + 1);
    dreq = '0;
    hostRead(regAddrT'(2 * ch + 1));
    hostRead(regAddrT'(2 * ch + 1));
    runBeats(1);
    quiesce();
    hostWrite(RegSingleMask, 8'h04 | byteT'(ch));

    // Fixed priority and back-pressure
    lo  = $urandom_range(0, NumCh - 2);
    cLo = $urandom_range(2, 5);
    programChannel(lo, wordT'($urandom), wordT'(cLo), 8'h00);
    programChannel(lo + 1, wordT'($urandom), wordT'($urandom_range(3, 6)), 8'h00);
    dreq[lo]     = 1'b1;
    dreq[lo + 1] = 1'b1;
    runBeats(cLo + 3);
    waitOffer();
    dreq = '0;
    repeat (8) tick();
    quiesce();
    // Every channel unmasked so that master clear has to mask them again
    hostWrite(RegAllMask, 8'h00);

    // Master clear
    hostWrite(RegMasterClear, 8'h00);
    ch = lo;
    hostRead(regAddrT'(2 * ch));
    hostRead(regAddrT'(2 * ch));
    hostRead(regAddrT'(2 * ch + 1));
    hostRead(regAddrT'(2 * ch + 1));
    dreq = '1;
    checkIdle(20);
    dreq = '0;
    repeat (3) tick();
    hostWrite(RegClearMask, 8'h00);
    dreq = '1;
    runBeats(NumCh);
    checkIdle(12);
    dreq = '0;

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* testbench/tbClock.sv */
// Clock and reset generator for the DMA controller testbench
module tbClock (
  output logic dif,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial
  begin
    dif = 1'b0;
    forever #2 dif = ~dif;
  end

  initial
  begin
    rstN = 1'b0;
    repeat (16) @(posedge dif);
    #1 rstN = 1'b1;
  end

endmodule

/* verilog/dmaChannelRegs.sv */
// Per-channel address, count, mode, mask and terminal-count state with read-back data
module dmaChannelRegs #(
  parameter int NumChannels = dmaPkg::MaxChannels
) (
  input  logic                   dif,
  input  logic                   rstN,
  input  logic                   opValid,
  input  dmaPkg::hostOpT         op,
  input  dmaPkg::chanT           opChannel,
  input  logic                   opHiByte,
  input  dmaPkg::byteT           opData,
  input  logic [NumChannels-1:0] dreq,
  input  dmaPkg::chanT           selChannel,
  input  logic                   stepValid,
  input  dmaPkg::chanT           stepChannel,
  input  logic                   stepLast,
  output dmaPkg::wordT           curAddr,
  output dmaPkg::wordT           curCount,
  output logic [NumChannels-1:0] mask,
  output dmaPkg::byteT           dataOut
);
  import dmaPkg::*;

  wordT                   baseAddr  [NumChannels];
  wordT                   baseCount [NumChannels];
  wordT                   curAddrR  [NumChannels];
  wordT                   curCountR [NumChannels];
  logic [NumChannels-1:0] autoInit;
  logic [NumChannels-1:0] decrement;
  logic [NumChannels-1:0] tcFlag;

  logic                   masterClear;
  logic                   wrAddrOp;
  logic                   wrCountOp;
  logic [NumChannels-1:0] opSel;
  logic [NumChannels-1:0] stepSel;
  logic [NumChannels-1:0] stepApply;
  logic [NumChannels-1:0] tcSet;
  wordT                   readWord;
  byteT                   readByte;
  byteT                   statusByte;

  assign masterClear = opValid && (op == OpMasterClear);
  assign wrAddrOp    = opValid && (op == OpWrAddr);
  assign wrCountOp   = opValid && (op == OpWrCount);

  always_comb
  begin
    for (int i = 0; i < NumChannels; i++)
    begin
      opSel[i]   = (opChannel == chanT'(i));
      stepSel[i] = stepValid && (stepChannel == chanT'(i));
    end
  end

  // Host write to the same channel wins over a step
  assign stepApply = stepSel & ~(opSel & {NumChannels{wrAddrOp | wrCountOp}});
  assign tcSet     = stepApply & {NumChannels{stepLast}};

  always_ff @(posedge dif or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < NumChannels; i++)
      begin
        baseAddr[i]  <= '0;
        baseCount[i] <= '0;
        curAddrR[i]  <= '0;
        curCountR[i] <= '0;
      end
    end
    else if (masterClear)
    begin
      for (int i = 0; i < NumChannels; i++)
      begin
        baseAddr[i]  <= '0;
        baseCount[i] <= '0;
        curAddrR[i]  <= '0;
        curCountR[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < NumChannels; i++)
      begin
        if (stepApply[i])
        begin
          // Terminal count with auto-initialize restarts from base
          if (stepLast && autoInit[i])
          begin
            curAddrR[i]  <= baseAddr[i];
            curCountR[i] <= baseCount[i];
          end
          else
          begin
            curAddrR[i]  <= decrement[i] ? curAddrR[i] - 1'b1 : curAddrR[i] + 1'b1;
            curCountR[i] <= curCountR[i] - 1'b1;
          end
        end
        if (wrAddrOp && opSel[i])
        begin
          if (opHiByte)
          begin
            baseAddr[i][15:8] <= opData;
            curAddrR[i][15:8] <= opData;
          end
          else
          begin
            baseAddr[i][7:0] <= opData;
            curAddrR[i][7:0] <= opData;
          end
        end
        if (wrCountOp && opSel[i])
        begin
          if (opHiByte)
          begin
            baseCount[i][15:8] <= opData;
            curCountR[i][15:8] <= opData;
          end
          else
          begin
            baseCount[i][7:0] <= opData;
            curCountR[i][7:0] <= opData;
          end
        end
      end
    end
  end

  always_ff @(posedge dif or negedge rstN)
  begin
    if (!rstN)
    begin
      autoInit  <= '0;
      decrement <= '0;
      mask      <= '1;
      tcFlag    <= '0;
    end
    else if (masterClear)
    begin
      autoInit  <= '0;
      decrement <= '0;
      mask      <= '1;
      tcFlag    <= '0;
    end
    else
    begin
      // A status read clears old flags, a flag raised in the same cycle stays
      if (opValid && op == OpRdStatus)
        tcFlag <= tcSet;
      else
        tcFlag <= tcFlag | tcSet;
      for (int i = 0; i < NumChannels; i++)
      begin
        if (tcSet[i] && !autoInit[i])
          mask[i] <= 1'b1;
      end
      if (opValid)
      begin
        case (op)
          OpWrMode:
          begin
            autoInit[opChannel]  <= opData[ModeAutoInitBit];
            decrement[opChannel] <= opData[ModeDecrementBit];
          end
          OpWrSingleMask:
            mask[opChannel] <= opData[MaskSetBit];
          OpWrAllMask:
            mask <= opData[NumChannels-1:0];
          OpClearMask:
            mask <= '0;
        endcase
      end
    end
  end

  // Status layout is TC flags low and request lines high
  always_comb
  begin
    statusByte = '0;
    statusByte[NumChannels-1:0] = tcFlag;
    statusByte[MaxChannels +: NumChannels] = dreq;
  end

  assign readWord = (op == OpRdCount) ? curCountR[opChannel] : curAddrR[opChannel];
  assign readByte = opHiByte ? readWord[15:8] : readWord[7:0];

  // Master clear leaves the last read value in place
  always_ff @(posedge dif or negedge rstN)
  begin
    if (!rstN)
      dataOut <= '0;
    else if (opValid && op == OpRdStatus)
      dataOut <= statusByte;
    else if (opValid && (op == OpRdAddr || op == OpRdCount))
      dataOut <= readByte;
  end

  assign curAddr  = curAddrR[selChannel];
  assign curCount = curCountR[selChannel];

endmodule

/* verilog/dmaCtl.sv */
// DMA controller top with host port, channel registers and transfer engine
module dmaCtl #(
  parameter int NumChannels = 4
) (
  input  logic                   dif,
  input  logic                   rstN,
  input  logic                   csN,
  input  logic                   iorN,
  input  logic                   iowN,
  input  dmaPkg::regAddrT        regAddr,
  input  dmaPkg::byteT           dataIn,
  output dmaPkg::byteT           dataOut,
  input  logic [NumChannels-1:0] dreq,
  output logic                   xferValid,
  input  logic                   xferReady,
  output dmaPkg::wordT           xferAddr,
  output dmaPkg::chanT           xferChannel,
  output logic                   xferLast
);
  import dmaPkg::*;

  // Host port to register file
  logic                   opValid;
  hostOpT                 op;
  chanT                   opChannel;
  logic                   opHiByte;
  byteT                   opData;

  // Engine and register file
  chanT                   selChannel;
  wordT                   curAddr;
  wordT                   curCount;
  logic [NumChannels-1:0] mask;
  logic                   stepValid;
  chanT                   stepChannel;
  logic                   stepLast;

  dmaHostPort #(
    .NumChannels(NumChannels)
  ) i_dmaHostPort (
    .dif      (dif),
    .rstN     (rstN),
    .csN      (csN),
    .iorN     (iorN),
    .iowN     (iowN),
    .regAddr  (regAddr),
    .dataIn   (dataIn),
    .opValid  (opValid),
    .op       (op),
    .opChannel(opChannel),
    .opHiByte (opHiByte),
    .opData   (opData)
  );

  dmaChannelRegs #(
    .NumChannels(NumChannels)
  ) i_dmaChannelRegs (
    .dif        (dif),
    .rstN       (rstN),
    .opValid    (opValid),
    .op         (op),
    .opChannel  (opChannel),
    .opHiByte   (opHiByte),
    .opData     (opData),
    .dreq       (dreq),
    .selChannel (selChannel),
    .stepValid  (stepValid),
    .stepChannel(stepChannel),
    .stepLast   (stepLast),
    .curAddr    (curAddr),
    .curCount   (curCount),
    .mask       (mask),
    .dataOut    (dataOut)
  );

  dmaTransferEngine #(
    .NumChannels(NumChannels)
  ) i_dmaTransferEngine (
    .dif        (dif),
    .rstN       (rstN),
    .dreq       (dreq),
    .mask       (mask),
    .curAddr    (curAddr),
    .curCount   (curCount),
    .xferReady  (xferReady),
    .selChannel (selChannel),
    .stepValid  (stepValid),
    .stepChannel(stepChannel),
    .stepLast   (stepLast),
    .xferValid  (xferValid),
    .xferAddr   (xferAddr),
    .xferChannel(xferChannel),
    .xferLast   (xferLast)
  );

endmodule

/* verilog/dmaHostPort.sv */
// CPU register port with strobe sampling, register decode and the byte pointer
module dmaHostPort #(
  parameter int NumChannels = dmaPkg::MaxChannels
) (
  input  logic            dif,
  input  logic            rstN,
  input  logic            csN,
  input  logic            iorN,
  input  logic            iowN,
  input  dmaPkg::regAddrT regAddr,
  input  dmaPkg::byteT    dataIn,
  output logic            opValid,
  output dmaPkg::hostOpT  op,
  output dmaPkg::chanT    opChannel,
  output logic            opHiByte,
  output dmaPkg::byteT    opData
);
  import dmaPkg::*;

  // Sampled strobes
  logic    rdQ;
  logic    wrQ;
  logic    rdPrev;
  logic    wrPrev;
  logic    rdStart;
  logic    wrStart;
  regAddrT addrQ;
  byteT    dataQ;
  logic    bytePtr;

  // Decoded access
  logic    decValid;
  hostOpT  decOp;
  chanT    decChannel;
  logic    decToggle;
  logic    decClearPtr;

  always_ff @(posedge dif or negedge rstN)
  begin
    if (!rstN)
    begin
      rdQ    <= 1'b0;
      wrQ    <= 1'b0;
      rdPrev <= 1'b0;
      wrPrev <= 1'b0;
    end
    else
    begin
      rdQ    <= ~csN & ~iorN;
      wrQ    <= ~csN & ~iowN;
      rdPrev <= rdQ;
      wrPrev <= wrQ;
    end
  end

  // Address and data are stable for the whole strobe
  always_ff @(posedge dif)
  begin
    addrQ <= regAddr;
    dataQ <= dataIn;
  end

  // One access per strobe assertion
  assign rdStart = rdQ & ~rdPrev;
  assign wrStart = wrQ & ~wrPrev;

  always_comb
  begin
    decValid    = 1'b0;
    decOp       = OpRdStatus;
    decChannel  = addrQ[2:1];
    decToggle   = 1'b0;
    decClearPtr = 1'b0;
    if (!addrQ[3])
    begin
      // Channel address and count registers, odd address is the count
      if ((rdStart || wrStart) && (int'(addrQ[2:1]) < NumChannels))
      begin
        decValid  = 1'b1;
        decToggle = 1'b1;
        if (wrStart)
          decOp = addrQ[0] ? OpWrCount : OpWrAddr;
        else
          decOp = addrQ[0] ? OpRdCount : OpRdAddr;
      end
    end
    else if (rdStart)
    begin
      decValid = (addrQ == RegStatus);
    end
    else if (wrStart)
    begin
      // Mode and single mask name their channel in the data byte
      decChannel = dataQ[1:0];
      case (addrQ)
        RegMode:
        begin
          decValid = (int'(dataQ[1:0]) < NumChannels);
          decOp    = OpWrMode;
        end
        RegSingleMask:
        begin
          decValid = (int'(dataQ[1:0]) < NumChannels);
          decOp    = OpWrSingleMask;
        end
        RegAllMask:
        begin
          decValid = 1'b1;
          decOp    = OpWrAllMask;
        end
        RegClearMask:
        begin
          decValid = 1'b1;
          decOp    = OpClearMask;
        end
        RegMasterClear:
        begin
          decValid    = 1'b1;
          decOp       = OpMasterClear;
          decClearPtr = 1'b1;
        end
        RegClearBytePtr:
          decClearPtr = 1'b1;
        default:
          decValid = 1'b0;
      endcase
    end
  end

  always_ff @(posedge dif or negedge rstN)
  begin
    if (!rstN)
    begin
      opValid <= 1'b0;
      bytePtr <= 1'b0;
    end
    else
    begin
      opValid <= decValid;
      if (decClearPtr)
        bytePtr <= 1'b0;
      else if (decToggle)
        bytePtr <= ~bytePtr;
    end
  end

  // Pointer value before the toggle selects the byte
  always_ff @(posedge dif)
  begin
    op        <= decOp;
    opChannel <= decChannel;
    opHiByte  <= bytePtr;
    opData    <= dataQ;
  end

endmodule

/* verilog/dmaPkg.sv */
// Package with data widths, register map, host operation codes and engine states
package dmaPkg;

  // Largest channel count the register map can address
  localparam int MaxChannels = 4;

  typedef logic [7:0]  byteT;
  typedef logic [15:0] wordT;
  typedef logic [1:0]  chanT;
  typedef logic [3:0]  regAddrT;
  typedef logic [3:0]  hostOpT;

  // Upper half of the register map
  // Addresses 0..7 alternate address and count registers of channels 0..3
  localparam regAddrT RegStatus       = 4'd8;
  localparam regAddrT RegSingleMask   = 4'd10;
  localparam regAddrT RegMode         = 4'd11;
  localparam regAddrT RegClearBytePtr = 4'd12;
  localparam regAddrT RegMasterClear  = 4'd13;
  localparam regAddrT RegClearMask    = 4'd14;
  localparam regAddrT RegAllMask      = 4'd15;

  // Host port operations
  localparam hostOpT OpWrAddr       = 4'd0;
  localparam hostOpT OpWrCount      = 4'd1;
  localparam hostOpT OpRdAddr       = 4'd2;
  localparam hostOpT OpRdCount      = 4'd3;
  localparam hostOpT OpRdStatus     = 4'd4;
  localparam hostOpT OpWrMode       = 4'd5;
  localparam hostOpT OpWrSingleMask = 4'd6;
  localparam hostOpT OpWrAllMask    = 4'd7;
  localparam hostOpT OpClearMask    = 4'd8;
  localparam hostOpT OpMasterClear  = 4'd9;

  // Mode byte, channel in bits 1:0
  localparam int ModeAutoInitBit  = 4;
  localparam int ModeDecrementBit = 5;

  // Single mask byte, channel in bits 1:0
  localparam int MaskSetBit = 2;

  typedef enum logic {
    engIdle,
    engOffer
  } engineStateE;

endpackage

/* verilog/dmaTransferEngine.sv */
// Fixed-priority request arbiter and valid/ready transfer-beat FSM
module dmaTransferEngine #(
  parameter int NumChannels = dmaPkg::MaxChannels
) (
  input  logic                   dif,
  input  logic                   rstN,
  input  logic [NumChannels-1:0] dreq,
  input  logic [NumChannels-1:0] mask,
  input  dmaPkg::wordT           curAddr,
  input  dmaPkg::wordT           curCount,
  input  logic                   xferReady,
  output dmaPkg::chanT           selChannel,
  output logic                   stepValid,
  output dmaPkg::chanT           stepChannel,
  output logic                   stepLast,
  output logic                   xferValid,
  output dmaPkg::wordT           xferAddr,
  output dmaPkg::chanT           xferChannel,
  output logic                   xferLast
);
  import dmaPkg::*;

  engineStateE            state;
  logic [NumChannels-1:0] reqQ;
  logic [NumChannels-1:0] candidate;
  logic                   found;
  chanT                   pick;
  chanT                   chanQ;
  logic                   accept;

  // Request lines are sampled, the mask is applied at decision time
  always_ff @(posedge dif or negedge rstN)
  begin
    if (!rstN)
      reqQ <= '0;
    else
      reqQ <= dreq;
  end

  assign candidate = reqQ & ~mask;
  assign found     = |candidate;

  // Lowest channel number has priority
  always_comb
  begin
    pick = '0;
    for (int i = NumChannels - 1; i >= 0; i--)
    begin
      if (candidate[i])
        pick = chanT'(i);
    end
  end

  always_ff @(posedge dif or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= engIdle;
      chanQ <= '0;
    end
    else
    begin
      case (state)
        engIdle:
        begin
          if (found)
          begin
            state <= engOffer;
            chanQ <= pick;
          end
        end
        engOffer:
        begin
          // Stays here until the beat is taken
          if (xferReady)
            state <= engIdle;
        end
        default:
          state <= engIdle;
      endcase
    end
  end

  assign xferValid   = (state == engOffer);
  assign accept      = xferValid && xferReady;
  assign selChannel  = chanQ;
  assign xferChannel = chanQ;
  assign xferAddr    = curAddr;
  assign xferLast    = (curCount == '0);

  // One step per accepted beat
  assign stepValid   = accept;
  assign stepChannel = chanQ;
  assign stepLast    = xferLast;

endmodule
